/* vend_money_pkg.sv */
package vend_money_pkg;

    ////////////////////////////////////////////////////////////
    // credit held by the machine
    ////////////////////////////////////////////////////////////

    // one unit is a 100 won coin
    typedef logic [7:0] credit_t;

    // two decimal digits on the money display
    localparam credit_t CREDIT_MAX = 8'd99;

    ////////////////////////////////////////////////////////////
    // coin values
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] coin_t;

    // 100 won
    localparam coin_t COIN_SMALL = 8'd1;

    // 500 won
    localparam coin_t COIN_MID = 8'd5;

    // 1000 won note slot
    localparam coin_t COIN_LARGE = 8'd10;

endpackage

/* vend_catalog_pkg.sv */
package vend_catalog_pkg;

    ////////////////////////////////////////////////////////////
    // product ids and stock
    ////////////////////////////////////////////////////////////

    // 0 is no item, 1 coke, 2 water, 3 juice
    typedef logic [1:0] item_t;

    // units on hand per product
    typedef logic [2:0] stock_t;

    localparam int NUM_ITEMS = 3;

    ////////////////////////////////////////////////////////////
    // catalog tables, entry 0 belongs to item 1
    ////////////////////////////////////////////////////////////

    // prices in credit units
    localparam vend_money_pkg::credit_t [NUM_ITEMS-1:0] PRICE = {
        8'd15,
        8'd12,
        8'd10
    };

    // juice starts sold out
    localparam stock_t [NUM_ITEMS-1:0] INIT_STOCK = {
        3'd0,
        3'd1,
        3'd4
    };

endpackage

/* vend_req_if.sv */
`timescale 1ns/100ps

// panel to ledger requests, one strobe per cycle at most
interface vend_req_if;

    logic                    coin_strobe;
    vend_money_pkg::coin_t   coin_value;
    logic                    buy_strobe;
    logic                    return_strobe;
    vend_catalog_pkg::item_t selected_item;

    modport panel (
        output coin_strobe,
        output coin_value,
        output buy_strobe,
        output return_strobe,
        output selected_item
    );

    modport ledger (
        input coin_strobe,
        input coin_value,
        input buy_strobe,
        input return_strobe,
        input selected_item
    );

endinterface

/* selection_control.sv */
`timescale 1ns/100ps

module selection_control (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] buttons,
    input  logic [2:0]  in_stock,
    input  logic        vend_strobe,
    output logic [1:0]  cursor,
    vend_req_if.panel   req
);

    logic                    up_btn;
    logic                    down_btn;
    logic                    select_btn;
    logic [2:0]              coin_btn;
    logic                    buy_btn;
    logic                    return_btn;
    vend_catalog_pkg::item_t cursor_item;
    vend_money_pkg::coin_t   coin_sel;
    logic                    coin_valid;

    // one-shot button map of the front panel
    assign up_btn     = buttons[10];
    assign down_btn   = buttons[4];
    assign select_btn = buttons[7];
    assign coin_btn   = buttons[2:0];
    assign buy_btn    = buttons[9];
    assign return_btn = buttons[3];

    // cursor 0..2 maps to item 1..3
    assign cursor_item = cursor + 2'd1;

    // only a single coin bit counts
    always_comb begin
        coin_valid = 1'b1;
        coin_sel   = vend_money_pkg::COIN_SMALL;
        case (coin_btn)
            3'b100: coin_sel = vend_money_pkg::COIN_SMALL;
            3'b010: coin_sel = vend_money_pkg::COIN_MID;
            3'b001: coin_sel = vend_money_pkg::COIN_LARGE;
            default: coin_valid = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // button priority, one action per cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor            <= 2'd0;
            req.selected_item <= '0;
            req.coin_strobe   <= 1'b0;
            req.buy_strobe    <= 1'b0;
            req.return_strobe <= 1'b0;
        end else begin
            req.coin_strobe   <= 1'b0;
            req.buy_strobe    <= 1'b0;
            req.return_strobe <= 1'b0;
            if (up_btn) begin
                if (cursor != 2'd0) begin
                    cursor <= cursor - 2'd1;
                end
            end else if (down_btn) begin
                if (cursor < 2'd2) begin
                    cursor <= cursor + 2'd1;
                end
            end else if (select_btn) begin
                // toggle off, or pick the item if any left
                if (req.selected_item == cursor_item) begin
                    req.selected_item <= '0;
                end else if (in_stock[cursor]) begin
                    req.selected_item <= cursor_item;
                end
            end else if (coin_btn != 3'b000) begin
                req.coin_strobe <= coin_valid;
            end else if (buy_btn) begin
                req.buy_strobe <= 1'b1;
            end else if (return_btn) begin
                req.return_strobe <= 1'b1;
            end
            // a completed sale drops the selection
            if (vend_strobe) begin
                req.selected_item <= '0;
            end
        end
    end

    // coin value rides along with coin_strobe
    always_ff @(posedge clk) begin
        if (coin_btn != 3'b000) begin
            req.coin_value <= coin_sel;
        end
    end

endmodule

/* stock_keeper.sv */
`timescale 1ns/100ps

module stock_keeper (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  vend_strobe,
    input  vend_catalog_pkg::item_t               vend_item,
    output logic [vend_catalog_pkg::NUM_ITEMS-1:0] in_stock
);

    ////////////////////////////////////////////////////////////
    // one counter per product
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < vend_catalog_pkg::NUM_ITEMS; i++) begin : g_item

        // item ids start at 1
        localparam vend_catalog_pkg::item_t ITEM_ID = vend_catalog_pkg::item_t'(i + 1);

        vend_catalog_pkg::stock_t count;
        logic                     take;

        // guard against underflow, sale only happens when in stock
        assign take = vend_strobe && (vend_item == ITEM_ID) && (count != '0);

        always_ff @(posedge clk) begin
            if (!rst) begin
                count <= vend_catalog_pkg::INIT_STOCK[i];
            end else if (take) begin
                count <= count - 3'd1;
            end
        end

        assign in_stock[i] = (count != '0);

    end

endmodule

/* credit_ledger.sv */
`timescale 1ns/100ps

module credit_ledger #(
    parameter int RETURN_TICKS = 1000000
) (
    input  logic                    clk,
    input  logic                    rst,
    vend_req_if.ledger              req,
    input  logic [2:0]              in_stock,
    output vend_money_pkg::credit_t credit,
    output logic                    vend_strobe,
    output vend_catalog_pkg::item_t vend_item,
    output logic                    change_pulse,
    output logic                    refund_busy
);

    localparam int TICK_W = (RETURN_TICKS > 1) ? $clog2(RETURN_TICKS) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(RETURN_TICKS - 1);

    typedef enum logic {
        LEDGER_IDLE,
        LEDGER_REFUND
    } ledger_state_t;

    ledger_state_t           state;
    logic [TICK_W-1:0]       tick_cnt;
    logic [8:0]              coin_sum;
    logic                    coin_fits;
    logic [1:0]              item_idx;
    vend_money_pkg::credit_t item_price;
    logic                    buy_ok;

    ////////////////////////////////////////////////////////////
    // coin and purchase checks
    ////////////////////////////////////////////////////////////

    // extra bit so an oversized coin value cannot wrap
    assign coin_sum  = {1'b0, credit} + {1'b0, req.coin_value};
    assign coin_fits = (coin_sum <= {1'b0, vend_money_pkg::CREDIT_MAX});

    // table row of the selected item
    assign item_idx   = req.selected_item - 2'd1;
    assign item_price = (req.selected_item != '0) ? vend_catalog_pkg::PRICE[item_idx] : '0;

    // credit equal to the price is enough
    assign buy_ok = (req.selected_item != '0) && in_stock[item_idx] &&
                    (credit >= item_price);

    // one change unit per tick period
    assign refund_busy  = (state == LEDGER_REFUND);
    assign change_pulse = refund_busy && (tick_cnt == TICK_LAST);

    ////////////////////////////////////////////////////////////
    // ledger FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= LEDGER_IDLE;
            credit      <= '0;
            tick_cnt    <= '0;
            vend_strobe <= 1'b0;
            vend_item   <= '0;
        end else begin
            vend_strobe <= 1'b0;
            vend_item   <= '0;
            case (state)
                LEDGER_IDLE: begin
                    if (req.coin_strobe) begin
                        if (coin_fits) begin
                            credit <= coin_sum[7:0];
                        end
                    end else if (req.buy_strobe) begin
                        if (buy_ok) begin
                            credit      <= credit - item_price;
                            vend_strobe <= 1'b1;
                            vend_item   <= req.selected_item;
                        end
                    end else if (req.return_strobe && (credit != '0)) begin
                        state    <= LEDGER_REFUND;
                        tick_cnt <= '0;
                    end
                end
                LEDGER_REFUND: begin
                    // coin and buy requests are dropped here
                    if (change_pulse) begin
                        tick_cnt <= '0;
                        credit   <= credit - 8'd1;
                        if (credit == 8'd1) begin
                            state <= LEDGER_IDLE;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= LEDGER_IDLE;
            endcase
        end
    end

endmodule

/* vend_top.sv */
`timescale 1ns/100ps

module vend_top #(
    parameter int RETURN_TICKS = 1000000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [11:0]             buttons,
    output vend_money_pkg::credit_t credit,
    output logic                    vend,
    output vend_catalog_pkg::item_t vend_item,
    output logic                    change_pulse,
    output logic                    refund_busy,
    output logic [1:0]              cursor,
    output vend_catalog_pkg::item_t selected_item,
    output logic [2:0]              sold_out
);

    logic       vend_strobe;
    logic [2:0] in_stock;

    vend_req_if req_bus ();

    ////////////////////////////////////////////////////////////
    // front panel, stock and money blocks
    ////////////////////////////////////////////////////////////

    selection_control i_selection_control (
        .clk         (clk),
        .rst         (rst),
        .buttons     (buttons),
        .in_stock    (in_stock),
        .vend_strobe (vend_strobe),
        .cursor      (cursor),
        .req         (req_bus.panel)
    );

    stock_keeper i_stock_keeper (
        .clk         (clk),
        .rst         (rst),
        .vend_strobe (vend_strobe),
        .vend_item   (vend_item),
        .in_stock    (in_stock)
    );

    credit_ledger #(
        .RETURN_TICKS (RETURN_TICKS)
    ) i_credit_ledger (
        .clk          (clk),
        .rst          (rst),
        .req          (req_bus.ledger),
        .in_stock     (in_stock),
        .credit       (credit),
        .vend_strobe  (vend_strobe),
        .vend_item    (vend_item),
        .change_pulse (change_pulse),
        .refund_busy  (refund_busy)
    );

    assign vend          = vend_strobe;
    assign selected_item = req_bus.selected_item;
    assign sold_out      = ~in_stock;

endmodule

/* vend_properties.sv */
`timescale 1ns/100ps

// ledger output rules
module vend_properties (
    input logic                    clk,
    input logic                    rst,
    input vend_money_pkg::credit_t credit,
    input logic                    vend_strobe,
    input vend_catalog_pkg::item_t vend_item,
    input logic                    change_pulse,
    input logic                    refund_busy
);

    int fail_count = 0;

    // coins and buys leave credit alone between change units
    a_refund_holds_credit: assert property (
        @(posedge clk) disable iff (!rst) (refund_busy && !change_pulse) |=> $stable(credit)
    ) else begin
        $error("credit moved between change units");
        fail_count++;
    end

    a_vend_has_item: assert property (
        @(posedge clk) disable iff (!rst) vend_strobe |-> (vend_item != '0)
    ) else begin
        $error("vend strobe without an item");
        fail_count++;
    end

    a_credit_ceiling: assert property (
        @(posedge clk) disable iff (!rst) credit <= vend_money_pkg::CREDIT_MAX
    ) else begin
        $error("credit above the ceiling");
        fail_count++;
    end

endmodule

bind credit_ledger vend_properties i_vend_properties (
    .clk          (clk),
    .rst          (rst),
    .credit       (credit),
    .vend_strobe  (vend_strobe),
    .vend_item    (vend_item),
    .change_pulse (change_pulse),
    .refund_busy  (refund_busy)
);

/* tb_clock.sv */
`timescale 1ns/100ps

// 10 ns clock, reset held low at start
module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps

module tb_checker #(
    parameter int RETURN_TICKS = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] buttons,
    input  logic [7:0]  credit,
    input  logic        vend,
    input  logic [1:0]  vend_item,
    input  logic        change_pulse,
    input  logic        refund_busy,
    input  logic [1:0]  cursor,
    input  logic [1:0]  selected_item,
    input  logic [2:0]  sold_out,
    input  logic        check_req,
    input  int          test_idx,
    input  logic [7:0]  exp_credit,
    input  logic [8:0]  exp_stock,
    output int          tests_done,
    output int          errors
);

    // machine model with items counted from 1
    int m_credit;
    int m_stock [3];
    int m_cursor;
    int m_sel;
    int last_item;
    int cyc;
    int refund_start;
    int refund_until;
    int exp_pulses;
    int seen_pulses;
    int exp_vends;
    int seen_vends;
    bit test_bad;

    function automatic int price_of(input int item);
        case (item)
            1: price_of = 10;
            2: price_of = 12;
            default: price_of = 15;
        endcase
    endfunction

    task automatic flag(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
        test_bad = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // one sampled button word in panel priority order
    ////////////////////////////////////////////////////////////

    task automatic apply_press(input logic [11:0] b);
        bit busy;
        int coin;
        busy = (cyc <= refund_until);
        coin = b[2] ? 1 : (b[1] ? 5 : 10);
        if (b[10]) begin
            if (m_cursor > 0)
                m_cursor--;
        end else if (b[4]) begin
            if (m_cursor < 2)
                m_cursor++;
        end else if (b[7]) begin
            if (m_sel == m_cursor + 1)
                m_sel = 0;
            else if (m_stock[m_cursor] > 0)
                m_sel = m_cursor + 1;
        end else if (b[2:0] != 3'b000) begin
            // credit stays within two digits
            if (!busy && $onehot(b[2:0]) && m_credit + coin <= 99)
                m_credit += coin;
        end else if (b[9]) begin
            if (!busy && m_sel != 0 && m_stock[m_sel - 1] > 0 &&
                m_credit >= price_of(m_sel)) begin
                m_credit -= price_of(m_sel);
                m_stock[m_sel - 1]--;
                last_item = m_sel;
                exp_vends++;
                m_sel = 0;
            end
        end else if (b[3]) begin
            // refund lasts one tick period per unit
            if (!busy && m_credit > 0) begin
                exp_pulses  += m_credit;
                refund_start = cyc;
                refund_until = cyc + m_credit * RETURN_TICKS;
                m_credit     = 0;
            end
        end
    endtask

    task automatic compare();
        int want;
        want = (exp_credit == 8'hFF) ? m_credit : int'(exp_credit);
        if (int'(credit) != want || m_credit != want)
            flag($sformatf("credit %0d, expected %0d, model %0d", credit, want, m_credit));
        for (int i = 0; i < 3; i++) begin
            if (m_stock[i] != int'(exp_stock[3*i +: 3]) || sold_out[i] != (m_stock[i] == 0))
                flag($sformatf("item %0d stock %0d, sold_out %b", i + 1, m_stock[i],
                               sold_out[i]));
        end
        if (int'(cursor) != m_cursor || int'(selected_item) != m_sel)
            flag($sformatf("cursor %0d selected %0d, expected %0d and %0d", cursor,
                           selected_item, m_cursor, m_sel));
        if (seen_pulses != exp_pulses)
            flag($sformatf("change pulses %0d, expected %0d", seen_pulses, exp_pulses));
        if (seen_vends != exp_vends)
            flag($sformatf("vends %0d, expected %0d", seen_vends, exp_vends));
        if (test_bad)
            $display("test %0d failed", test_idx);
        else
            $display("test %0d ok, credit %0d", test_idx, credit);
        test_bad = 1'b0;
        tests_done++;
    endtask

    always @(posedge clk) begin
        bit want_busy;
        if (!rst) begin
            m_credit     = 0;
            m_stock      = '{4, 1, 0};
            m_cursor     = 0;
            m_sel        = 0;
            last_item    = 0;
            cyc          = 0;
            refund_start = 0;
            refund_until = -1;
            exp_pulses   = 0;
            seen_pulses  = 0;
            exp_vends    = 0;
            seen_vends   = 0;
            test_bad     = 1'b0;
            tests_done   = 0;
            errors       = 0;
        end else begin
            cyc++;
            // busy from two cycles after the return press until the last unit is paid
            want_busy = (cyc >= refund_start + 2) && (cyc <= refund_until + 1);
            if (refund_busy != want_busy)
                flag($sformatf("refund_busy %b, expected %b", refund_busy, want_busy));
            if (change_pulse)
                seen_pulses++;
            if (vend) begin
                seen_vends++;
                if (int'(vend_item) != last_item)
                    flag($sformatf("vend item %0d, expected %0d", vend_item, last_item));
            end
            apply_press(buttons);
            if (check_req)
                compare();
        end
    end

endmodule

/* tb_vend.sv */
`timescale 1ns/100ps

module tb_vend;

    localparam int RETURN_TICKS = 4;
    localparam int NUM_TESTS    = 23;
    localparam int GAP          = 3;
    localparam int SETTLE       = 6;
    // every row is allowed one full refund from the credit ceiling
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * (int'(vend_money_pkg::CREDIT_MAX) * RETURN_TICKS + 100);

    // front panel bit positions
    localparam logic [11:0] BTN_FILL   = 12'h000;
    localparam logic [11:0] BTN_UP     = 12'h400;
    localparam logic [11:0] BTN_BUY    = 12'h200;
    localparam logic [11:0] BTN_SELECT = 12'h080;
    localparam logic [11:0] BTN_DOWN   = 12'h010;
    localparam logic [11:0] BTN_RETURN = 12'h008;
    localparam logic [11:0] BTN_C1     = 12'h004;
    localparam logic [11:0] BTN_C5     = 12'h002;
    localparam logic [11:0] BTN_C10    = 12'h001;
    // credit left to the model after random coins
    localparam logic [7:0]  ANY        = 8'hFF;

    // stock column is juice, water, coke in octal digits
    typedef struct packed {
        logic [11:0] btn;
        logic [7:0]  reps;
        logic [7:0]  credit;
        logic [8:0]  stock;
    } row_t;

    logic                    clk;
    logic                    rst;
    logic [11:0]             buttons;
    vend_money_pkg::credit_t credit;
    logic                    vend;
    vend_catalog_pkg::item_t vend_item;
    logic                    change_pulse;
    logic                    refund_busy;
    logic [1:0]              cursor;
    vend_catalog_pkg::item_t selected_item;
    logic [2:0]              sold_out;
    logic                    check_req;
    int                      test_idx;
    logic [7:0]              exp_credit;
    logic [8:0]              exp_stock;
    int                      tests_done;
    int                      errors;
    logic [7:0]              lfsr;
    row_t                    rows [NUM_TESTS];

    tb_clock #(.RESET_CYCLES(10)) clock_gen (.clk(clk), .rst(rst));

    vend_top #(.RETURN_TICKS(RETURN_TICKS)) i_vend_top (
        .clk(clk), .rst(rst), .buttons(buttons), .credit(credit), .vend(vend),
        .vend_item(vend_item), .change_pulse(change_pulse), .refund_busy(refund_busy),
        .cursor(cursor), .selected_item(selected_item), .sold_out(sold_out)
    );

    tb_checker #(.RETURN_TICKS(RETURN_TICKS)) scoreboard (
        .clk(clk), .rst(rst), .buttons(buttons), .credit(credit), .vend(vend),
        .vend_item(vend_item), .change_pulse(change_pulse), .refund_busy(refund_busy),
        .cursor(cursor), .selected_item(selected_item), .sold_out(sold_out),
        .check_req(check_req), .test_idx(test_idx), .exp_credit(exp_credit),
        .exp_stock(exp_stock), .tests_done(tests_done), .errors(errors)
    );

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // galois form with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic pick_coin(output logic [11:0] code);
        logic [1:0] pick;
        pick[0] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        pick[1] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        case (pick)
            2'd0: code = BTN_C1;
            2'd1: code = BTN_C5;
            default: code = BTN_C10;
        endcase
    endtask

    // one-cycle press followed by idle cycles
    task automatic press(input logic [11:0] code);
        @(posedge clk);
        buttons <= code;
        @(posedge clk);
        buttons <= '0;
        repeat (GAP) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // test table and main loop
    ////////////////////////////////////////////////////////////

    initial begin
        logic [11:0] code;
        buttons   = '0;
        check_req = 1'b0;
        test_idx  = 0;
        exp_credit = '0;
        exp_stock = '0;
        lfsr      = 8'd13;
        rows[0]  = '{BTN_C1,     8'd3, 8'd3,  9'o014};
        rows[1]  = '{BTN_C5,     8'd2, 8'd13, 9'o014};
        rows[2]  = '{BTN_C10,    8'd8, 8'd93, 9'o014};
        rows[3]  = '{BTN_C5,     8'd2, 8'd98, 9'o014};
        rows[4]  = '{BTN_C1,     8'd2, 8'd99, 9'o014};
        rows[5]  = '{BTN_RETURN, 8'd1, 8'd0,  9'o014};
        rows[6]  = '{BTN_UP,     8'd2, 8'd0,  9'o014};
        rows[7]  = '{BTN_DOWN,   8'd5, 8'd0,  9'o014};
        rows[8]  = '{BTN_SELECT, 8'd1, 8'd0,  9'o014};
        rows[9]  = '{BTN_UP,     8'd1, 8'd0,  9'o014};
        rows[10] = '{BTN_SELECT, 8'd2, 8'd0,  9'o014};
        rows[11] = '{BTN_SELECT, 8'd1, 8'd0,  9'o014};
        rows[12] = '{BTN_C10,    8'd1, 8'd10, 9'o014};
        rows[13] = '{BTN_BUY,    8'd1, 8'd10, 9'o014};
        rows[14] = '{BTN_C1,     8'd2, 8'd12, 9'o014};
        rows[15] = '{BTN_BUY,    8'd1, 8'd0,  9'o004};
        rows[16] = '{BTN_SELECT, 8'd1, 8'd0,  9'o004};
        rows[17] = '{BTN_UP,     8'd1, 8'd0,  9'o004};
        rows[18] = '{BTN_SELECT, 8'd1, 8'd0,  9'o004};
        rows[19] = '{BTN_FILL,   8'd6, ANY,   9'o004};
        rows[20] = '{BTN_C10,    8'd1, ANY,   9'o004};
        rows[21] = '{BTN_BUY,    8'd1, ANY,   9'o003};
        rows[22] = '{BTN_RETURN, 8'd1, 8'd0,  9'o003};
        @(posedge rst);
        repeat (2) @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int r = 0; r < int'(rows[t].reps); r++) begin
                code = rows[t].btn;
                if (rows[t].btn == BTN_FILL)
                    pick_coin(code);
                press(code);
            end
            // coins fed into a running refund
            @(negedge clk);
            if (refund_busy) begin
                repeat (3) begin
                    pick_coin(code);
                    press(code);
                end
            end
            @(negedge clk);
            while (refund_busy) @(negedge clk);
            repeat (SETTLE) @(posedge clk);
            test_idx   <= t;
            exp_credit <= rows[t].credit;
            exp_stock  <= rows[t].stock;
            check_req  <= 1'b1;
            @(posedge clk);
            check_req  <= 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("summary: %0d of %0d tests checked, %0d errors, %0d assertion failures",
                 tests_done, NUM_TESTS, errors,
                 i_vend_top.i_credit_ledger.i_vend_properties.fail_count);
        if (errors == 0 && tests_done == NUM_TESTS &&
            i_vend_top.i_credit_ledger.i_vend_properties.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* src.f */
vend_money_pkg.sv
vend_catalog_pkg.sv
vend_req_if.sv
selection_control.sv
stock_keeper.sv
credit_ledger.sv
vend_top.sv
vend_properties.sv
tb_clock.sv
tb_checker.sv
tb_vend.sv

/* run.sh */
#!/bin/sh
# build and run the vending machine testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_vend -o vend_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/vend_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }
